// ==== sources.f ====
verilog/fetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/icache_dual.sv
verilog/predecode.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
testbench/tb_clk_gen.sv
testbench/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_top -f sources.f

./obj_dir/Vtb_fetch_top | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== testbench/tb_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top import fetch_pkg::*; ();

    localparam int    MEM_WORDS    = 256;
    localparam int    EXP_PAIRS    = 35;    // 7 + 7 + 8 + 8 held + 5 at the end
    localparam int    HOLD_CYCLES  = 120;
    localparam int    NUM_JUMPS    = 3;     // jumps answered from the target table
    localparam int    TIMEOUT_NS   = EXP_PAIRS * 200 * 10;
    localparam addr_t LAST_JUMP    = 32'h0000_03a0;
    localparam addr_t DECOY_TARGET = 32'h0000_0300;

    logic        clk;
    logic        rst;
    logic        mem_req;
    addr_t       mem_addr;
    logic        mem_valid = 1'b0;
    word_t       mem_data = '0;
    logic        jmp_en0;
    addr_t       jmp_addr0;
    logic        jmp_en1;
    addr_t       jmp_addr1;
    logic        dec_valid;
    fetch_pair_t dec_pair;
    logic        dec_credit = 1'b0;

    word_t      mem [MEM_WORDS];        // big-endian program image
    int         req_cnt [MEM_WORDS];
    logic       mem_busy = 1'b0;
    logic [7:0] mem_word;
    int         mem_wait;
    logic       hold_credits;
    int         owed = 0;
    addr_t      exp_pc = RESET_PC;
    logic       wait_redirect = 1'b0;
    addr_t      redir_target = RESET_PC;   // where fetch must resume
    int         beats = 0;
    int         returned = 0;
    int         pairs = 0;
    int         jumps_seen = 0;
    addr_t      last_jump_pc;
    int         errors = 0;

    tb_clk_gen i_clk_gen (.clk);

    fetch_top i_dut (
        .clk, .rst, .mem_req, .mem_addr, .mem_valid, .mem_data,
        .jmp_en0, .jmp_addr0, .jmp_en1, .jmp_addr1,
        .dec_valid, .dec_pair, .dec_credit
    );

    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // expected core-order word at a, returns its jump flag
    function automatic logic ref_fetch(input addr_t a, output word_t w);
        w = swap_bytes(mem[a[9:2]]);
        return (w[6:0] == OPC_JAL) || (w[6:0] == OPC_JALR && w[14:12] == 3'b000);
    endfunction

    function automatic addr_t jump_site(input int k);
        return (k < 2) ? 32'h0000_0030 : 32'h0000_0138;
    endfunction

    function automatic addr_t jump_target(input int k);
        case (k)
            0:       return 32'h0000_0000;  // second pass over the loop
            1:       return 32'h0000_0100;
            default: return 32'h0000_0200;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic place_jal(input addr_t a);
        word_t instr;
        instr      = $urandom;
        instr[6:0] = OPC_JAL;
        mem[a[9:2]] = swap_bytes(instr);
    endtask

    task automatic load_program();
        word_t instr;
        for (int i = 0; i < MEM_WORDS; i++) begin
            instr = $urandom;
            if (instr[6:0] == OPC_JAL || instr[6:0] == OPC_JALR) begin
                instr[6:0] = 7'b0010011;
            end
            mem[i]     = swap_bytes(instr);
            req_cnt[i] = 0;
        end
        // jumps sit at even word offsets so they land in slot x
        place_jal(32'h0000_0030);
        place_jal(32'h0000_0138);
        place_jal(LAST_JUMP);
    endtask

    task automatic send_redirect(input logic en0, input logic en1,
                                 input addr_t a0, input addr_t a1);
        @(posedge clk);
        #1;
        jmp_en0   = en0;
        jmp_en1   = en1;
        jmp_addr0 = a0;
        jmp_addr1 = a1;
        @(posedge clk);
        #1;
        jmp_en0 = 1'b0;
        jmp_en1 = 1'b0;
    endtask

    // memory answers 1 to 4 cycles after it sees mem_req
    always @(posedge clk) begin
        if (mem_valid) begin
            #1;
            mem_valid = 1'b0;
            mem_busy  = 1'b0;
        end else if (mem_req || mem_busy) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_word = mem_addr[9:2];
                mem_wait = $urandom % 4;
                req_cnt[mem_word]++;
            end else begin
                mem_wait--;
            end
            if (mem_wait == 0) begin
                #1;
                mem_valid = 1'b1;
                mem_data  = mem[mem_word];
            end
        end
    end

    // decoder frees its entries after random delays
    always @(posedge clk) begin
        if (dec_valid) begin
            owed++;
        end
        #1;
        dec_credit = 1'b0;
        if (!hold_credits && owed > 0 && ($urandom % 2) == 0) begin
            dec_credit = 1'b1;
            owed--;
        end
    end

    always @(posedge clk) begin : compare_pairs
        word_t exp_x;
        word_t exp_y;
        logic  exp_jump;
        if (!rst) begin
            if (dec_valid) begin
                if (wait_redirect) begin
                    $display("pair at 0x%08h delivered while a redirect was due", dec_pair.pc_x);
                    errors++;
                end
                exp_jump = ref_fetch(exp_pc, exp_x);
                check_value("dec_pair.pc_x", dec_pair.pc_x, exp_pc);
                check_value("dec_pair.word_x", dec_pair.word_x, exp_x);
                check_value("dec_pair.valid_x", 32'(dec_pair.valid_x), 32'h1);
                check_value("dec_pair.jump_x", 32'(dec_pair.jump_x), 32'(exp_jump));
                if (exp_jump) begin
                    check_value("dec_pair.valid_y", 32'(dec_pair.valid_y), 32'h0);
                    wait_redirect = 1'b1;
                end else if (dec_pair.valid_y) begin
                    void'(ref_fetch(exp_pc + 32'd4, exp_y));
                    check_value("dec_pair.word_y", dec_pair.word_y, exp_y);
                    exp_pc = exp_pc + 32'd8;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
                if (dec_pair.jump_x) begin      // execute reacts to the flag it sees
                    last_jump_pc = dec_pair.pc_x;
                    jumps_seen++;
                end
                pairs++;
                beats++;
            end
            if (dec_credit) begin
                returned++;
            end
            if (beats > returned + DEC_CREDITS) begin
                $display("credit overrun: %0d beats with %0d credits returned", beats, returned);
                errors++;
            end
            if (jmp_en0 || jmp_en1) begin
                exp_pc        = redir_target;
                wait_redirect = 1'b0;
            end
        end
    end

    initial begin
        #TIMEOUT_NS;
        $display("timeout: run not finished after %0d cycles", EXP_PAIRS * 200);
        $display("errors: %0d, pairs checked: %0d", errors, pairs);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic use0;
        void'($urandom(32'h3d54));
        rst          = 1'b1;
        jmp_en0      = 1'b0;
        jmp_en1      = 1'b0;
        jmp_addr0    = '0;
        jmp_addr1    = '0;
        hold_credits = 1'b0;
        load_program();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int k = 0; k < NUM_JUMPS; k++) begin
            wait (jumps_seen > k);
            check_value("jump pc_x", last_jump_pc, jump_site(k));
            repeat ($urandom % 5) @(posedge clk);   // 2 to 6 cycles after the jump pair
            redir_target = jump_target(k);
            if (k == NUM_JUMPS - 1) begin
                hold_credits = 1'b1;
                send_redirect(1'b1, 1'b1, jump_target(k), DECOY_TARGET);
            end else begin
                use0 = 1'($urandom % 2);
                // idle port carries a decoy address
                if (use0) begin
                    send_redirect(1'b1, 1'b0, jump_target(k), DECOY_TARGET);
                end else begin
                    send_redirect(1'b0, 1'b1, DECOY_TARGET, jump_target(k));
                end
            end
        end

        // queue fills while no credit comes back, then gets flushed
        repeat (HOLD_CYCLES) @(posedge clk);
        check_value("dec_valid", 32'(dec_valid), 32'h0);
        redir_target = 32'h0000_0380;
        send_redirect(1'b1, 1'b1, 32'h0000_0380, 32'h0000_03c0);
        hold_credits = 1'b0;

        wait (jumps_seen > NUM_JUMPS);
        check_value("jump pc_x", last_jump_pc, LAST_JUMP);
        repeat (20) @(posedge clk);
        for (int i = 0; i < 14; i++) begin
            check_value($sformatf("req_cnt[%0d]", i), req_cnt[i], 32'h1);
        end

        $display("errors: %0d, pairs checked: %0d", errors, pairs);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    localparam int HALF_NS = 5;     // 10 ns period

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    // memory
    output wire              mem_req,
    output wire addr_t       mem_addr,
    input  wire              mem_valid,
    input  wire word_t       mem_data,
    // execute redirects
    input  wire              jmp_en0,
    input  wire addr_t       jmp_addr0,
    input  wire              jmp_en1,
    input  wire addr_t       jmp_addr1,
    // decoder
    output wire              dec_valid,
    output wire fetch_pair_t dec_pair,
    input  wire              dec_credit
);

    addr_t       pcx;
    addr_t       pcy;
    addr_t       fill_addr;
    word_t       data_x;
    word_t       data_y;
    logic        hit_x;
    logic        hit_y;
    logic        jump_x;
    logic        can_enq;
    logic        fill_en;
    logic        enq;
    logic        flush;
    logic        valid_y;
    fetch_pair_t enq_pair;

    fetch_ctrl i_ctrl (
        .clk, .rst, .hit_x, .hit_y, .jump_x, .can_enq, .mem_valid,
        .jmp_en0, .jmp_en1, .jmp_addr0, .jmp_addr1,
        .pcx, .pcy, .mem_addr, .fill_addr,
        .mem_req, .fill_en, .enq, .flush, .valid_y
    );

    icache_dual i_cache (
        .clk, .rst, .pcx, .pcy, .hit_x, .hit_y, .data_x, .data_y,
        .fill_en, .fill_addr, .fill_data(mem_data)
    );

    predecode i_predecode (
        .pcx, .raw_x(data_x), .raw_y(data_y), .valid_y_in(valid_y),
        .jump_x, .pair(enq_pair)
    );

    fetch_queue i_queue (
        .clk, .rst, .enq, .flush, .enq_pair, .can_enq,
        .dec_credit, .dec_valid, .dec_pair
    );

endmodule

`default_nettype wire

// ==== verilog/fetch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_queue import fetch_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              enq,
    input  wire              flush,
    input  wire fetch_pair_t enq_pair,
    output logic             can_enq,
    input  wire              dec_credit,
    output logic             dec_valid,
    output fetch_pair_t      dec_pair
);

    fetch_pair_t entries [QUEUE_DEPTH];
    qptr_t       wr_ptr;
    qptr_t       rd_ptr;
    qcount_t     count;
    credit_t     credits;
    logic        push;
    logic        pop;

    assign can_enq = (count != qcount_t'(QUEUE_DEPTH));
    assign push    = enq & can_enq & ~flush;

    // head goes out whenever the decoder has room
    assign dec_valid = (count != '0) && (credits != '0) && !flush;
    assign dec_pair  = entries[rd_ptr];
    assign pop       = dec_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= credit_t'(DEC_CREDITS);
        end else begin
            // credits survive a flush, sent entries belong to the decoder
            credits <= credits - credit_t'(pop) + credit_t'(dec_credit);
            if (flush) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                count <= count + qcount_t'(push) - qcount_t'(pop);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= enq_pair;
        end
    end

    // decoder never hands back more than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= credit_t'(DEC_CREDITS));

endmodule

`default_nettype wire

// ==== verilog/predecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module predecode import fetch_pkg::*; (
    input  wire addr_t pcx,
    input  wire word_t raw_x,
    input  wire word_t raw_y,
    input  wire        valid_y_in,
    output logic       jump_x,
    output fetch_pair_t pair
);

    word_t sw_x;
    word_t sw_y;

    // memory is big-endian, the core wants little-endian words
    function automatic word_t bswap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic is_jump(input word_t w);
        opcode_t opc;
        funct3_t f3;
        opc = w[6:0];
        f3  = w[14:12];
        return (opc == OPC_JAL) || (opc == OPC_JALR && f3 == F3_JALR);
    endfunction

    assign sw_x   = bswap(raw_x);
    assign sw_y   = bswap(raw_y);
    assign jump_x = is_jump(sw_x);

    always_comb begin
        pair.pc_x    = pcx;
        pair.word_x  = sw_x;
        pair.valid_x = 1'b1;                    // only hits are enqueued
        pair.word_y  = sw_y;
        pair.valid_y = valid_y_in & ~jump_x;    // y squashed behind a jump
        pair.jump_x  = jump_x;
    end

endmodule

`default_nettype wire

// ==== verilog/icache_dual.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_dual import fetch_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire addr_t pcx,
    input  wire addr_t pcy,
    output logic       hit_x,
    output logic       hit_y,
    output word_t      data_x,
    output word_t      data_y,
    input  wire        fill_en,
    input  wire addr_t fill_addr,
    input  wire word_t fill_data
);

    tag_t                   tags  [CACHE_LINES];
    word_t                  words [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid;

    line_idx_t idx_x;
    line_idx_t idx_y;
    line_idx_t idx_f;
    tag_t      tag_x;
    tag_t      tag_y;
    tag_t      tag_f;

    function automatic line_idx_t line_idx(input addr_t a);
        return a[IDX_LSB +: $bits(line_idx_t)];
    endfunction

    function automatic tag_t line_tag(input addr_t a);
        return a[TAG_LSB +: $bits(tag_t)];
    endfunction

    assign idx_x = line_idx(pcx);
    assign idx_y = line_idx(pcy);
    assign idx_f = line_idx(fill_addr);
    assign tag_x = line_tag(pcx);
    assign tag_y = line_tag(pcy);
    assign tag_f = line_tag(fill_addr);

    // both read ports are plain lookups, no bypass from the fill port
    assign hit_x  = valid[idx_x] && (tags[idx_x] == tag_x);
    assign hit_y  = valid[idx_y] && (tags[idx_y] == tag_y);
    assign data_x = words[idx_x];
    assign data_y = words[idx_y];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[idx_f] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[idx_f]  <= tag_f;
            words[idx_f] <= fill_data;          // still in memory byte order
        end
    end

    // refills are only started on a miss, so a fill never rewrites a live line
    a_fill_on_miss: assert property (@(posedge clk) disable iff (rst)
        fill_en |-> !(valid[idx_f] && tags[idx_f] == tag_f));

endmodule

`default_nettype wire

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl import fetch_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        hit_x,
    input  wire        hit_y,
    input  wire        jump_x,
    input  wire        can_enq,
    input  wire        mem_valid,
    input  wire        jmp_en0,
    input  wire        jmp_en1,
    input  wire addr_t jmp_addr0,
    input  wire addr_t jmp_addr1,
    output addr_t      pcx,
    output addr_t      pcy,
    output addr_t      mem_addr,
    output addr_t      fill_addr,
    output logic       mem_req,
    output logic       fill_en,
    output logic       enq,
    output logic       flush,
    output logic       valid_y
);

    fetch_state_t state;
    logic         redir_pend;      // redirect parked behind a refill
    addr_t        redir_addr;
    logic         redir_now;
    addr_t        redir_now_addr;
    logic         mem_busy;
    logic         take_redir;
    addr_t        target;

    assign redir_now      = jmp_en0 | jmp_en1;
    assign redir_now_addr = jmp_en0 ? jmp_addr0 : jmp_addr1;   // port 0 wins
    assign mem_busy       = mem_req & ~mem_valid;
    assign take_redir     = (redir_now | redir_pend) & ~mem_busy;
    assign target         = redir_now ? redir_now_addr : redir_addr;

    // queue is emptied as soon as execute redirects
    assign flush     = redir_now;
    assign enq       = (state == FETCH) & hit_x & can_enq & ~redir_now & ~redir_pend;
    assign valid_y   = hit_y;
    assign fill_en   = mem_req & mem_valid;
    assign fill_addr = mem_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= FETCH;
            pcx        <= RESET_PC;
            pcy        <= RESET_PC + 32'd4;
            mem_req    <= 1'b0;
            redir_pend <= 1'b0;
        end else if (take_redir) begin
            state      <= FETCH;
            pcx        <= target;
            pcy        <= target + 32'd4;
            mem_req    <= 1'b0;
            redir_pend <= 1'b0;
        end else begin
            if (redir_now) begin
                redir_pend <= 1'b1;
                redir_addr <= redir_now_addr;
            end
            case (state)
                FETCH: begin
                    if (can_enq) begin
                        if (!hit_x) begin
                            state    <= REFILL_X;
                            mem_req  <= 1'b1;
                            mem_addr <= pcx;
                        end else if (jump_x) begin
                            state <= JMP_WAIT;      // wait for execute
                        end else if (hit_y) begin
                            pcx <= pcx + 32'd8;
                            pcy <= pcy + 32'd8;
                        end else begin
                            pcx <= pcy;
                            pcy <= pcy + 32'd4;
                        end
                    end
                end
                REFILL_X: begin
                    if (mem_valid) begin
                        mem_req <= 1'b0;
                        if (!hit_y) begin
                            // y line missing too, fetch it before the pair goes out
                            state    <= REFILL_Y;
                            mem_addr <= pcy;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                REFILL_Y: begin
                    if (!mem_req) begin
                        mem_req <= 1'b1;            // one idle cycle between requests
                    end else if (mem_valid) begin
                        mem_req <= 1'b0;
                        state   <= FETCH;
                    end
                end
                JMP_WAIT: begin
                    state <= JMP_WAIT;              // left only through a redirect
                end
                default: state <= FETCH;
            endcase
        end
    end

    // memory sees a steady request until it answers
    a_mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_valid |=> mem_req && $stable(mem_addr));

endmodule

`default_nettype wire

// ==== verilog/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int CACHE_LINES = 32;                // one word per line
    localparam int QUEUE_DEPTH = 4;                 // pair entries
    localparam int DEC_CREDITS = 4;                 // decoder input buffer size

    localparam int IDX_LSB = 2;
    localparam int TAG_LSB = 7;

    localparam int QPTR_W   = $clog2(QUEUE_DEPTH);
    localparam int CREDIT_W = $clog2(DEC_CREDITS + 1);

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  line_idx_t;                // addr[6:2]
    typedef logic [24:0] tag_t;                     // addr[31:7]
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    typedef logic [QPTR_W-1:0]   qptr_t;
    typedef logic [QPTR_W:0]     qcount_t;
    typedef logic [CREDIT_W-1:0] credit_t;

    localparam addr_t RESET_PC = 32'h0000_0000;

    localparam opcode_t OPC_JAL  = 7'b1101111;
    localparam opcode_t OPC_JALR = 7'b1100111;
    localparam funct3_t F3_JALR  = 3'b000;

    // pc of slot y is pc_x + 4
    typedef struct packed {
        addr_t pc_x;
        word_t word_x;
        logic  valid_x;
        word_t word_y;
        logic  valid_y;
        logic  jump_x;
    } fetch_pair_t;

    typedef enum logic [1:0] {
        FETCH,
        REFILL_X,
        REFILL_Y,
        JMP_WAIT
    } fetch_state_t;

endpackage

`default_nettype wire
